// ==== include/frogger_params.svh ====
// frogger scene constants: screen span, lane geometry, object widths and colours
`ifndef FROGGER_PARAMS_SVH
`define FROGGER_PARAMS_SVH

// ----------------------------------------
// geometry
// ----------------------------------------

`define FROG_SCREEN_SPAN 680    // x at or above this means the object has wrapped
`define FROG_LANE_H      40     // rows per lane
`define FROG_CAR_W       80
`define FROG_PAD_W       40

// top row of lane 0, later lanes step down by one lane height
`define FROG_ROAD_TOP    280
`define FROG_RIVER_TOP   80

// ----------------------------------------
// colours, {red, green, blue}
// ----------------------------------------

// scenery
`define FROG_RGB_WATER   {8'd0, 8'd200, 8'd255}
`define FROG_RGB_BAY     {8'd0, 8'd100, 8'd0}     // dark grass goal bays
`define FROG_RGB_GRASS   {8'd0, 8'd200, 8'd0}
`define FROG_RGB_STRIPE  {8'd255, 8'd204, 8'd0}   // lane dashes
`define FROG_RGB_ROAD    {8'd69, 8'd69, 8'd69}
`define FROG_RGB_BLANK   {8'd255, 8'd255, 8'd255}

// objects
`define FROG_RGB_PAD     {8'd0, 8'd250, 8'd0}
`define FROG_RGB_CAR_R   {8'd200, 8'd0, 8'd0}     // road lanes 0 and 2
`define FROG_RGB_CAR_L   {8'd0, 8'd0, 8'd200}     // road lanes 1 and 3

`endif

// ==== logic/frogger_pkg.sv ====
// frogger pixel types: screen coordinates, colours and per-lane object slots
package frogger_pkg;

	// ----------------------------------------
	// screen space
	// ----------------------------------------

	// 11 bits covers the full span plus wrapped x positions
	typedef logic [10:0] coord_t;

	// ----------------------------------------
	// colour
	// ----------------------------------------

	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// ----------------------------------------
	// lane contents
	// ----------------------------------------

	// x of each of the four object slots in one lane
	typedef coord_t [3:0] lane_slots_t;

	// live objects in a lane, 0 to 4
	// slots at or above the count are never drawn
	typedef logic [2:0] slot_count_t;

endpackage

// ==== logic/pixel_layer_if.sv ====
// pixel layer bus: stage-one object and background results toward the compositor
`timescale 1ns/1ns

interface pixel_layer_if;

	logic               valid;      // one per draw strobe, no back-pressure
	logic               obj_hit;    // some lane object covers the pixel
	frogger_pkg::rgb_t  obj_color;  // colour of the winning object
	frogger_pkg::rgb_t  bg_color;   // scenery under the pixel

	// object layer drives the strobe and the object result
	modport object_src
	(
		output valid,
		output obj_hit,
		output obj_color
	);

	modport scene_src
	(
		output bg_color
	);

	// compositor consumes every valid on the edge it is present
	modport sink
	(
		input valid,
		input obj_hit,
		input obj_color,
		input bg_color
	);

endinterface

// ==== logic/lane_row_match.sv ====
// lane row match: hit test of one lane's four object slots against the draw coordinate
`timescale 1ns/1ns
`include "frogger_params.svh"

module lane_row_match
#(
	parameter int OBJ_WIDTH = `FROG_CAR_W,
	parameter int LANE_TOP  = `FROG_ROAD_TOP
)
(
	input  frogger_pkg::coord_t      draw_x,
	input  frogger_pkg::coord_t      draw_y,
	input  frogger_pkg::lane_slots_t slot_x,
	input  frogger_pkg::slot_count_t slot_count,
	output logic                     lane_hit
);

	localparam frogger_pkg::coord_t OBJ_SPAN    = frogger_pkg::coord_t'(OBJ_WIDTH);
	localparam frogger_pkg::coord_t SCREEN_SPAN = frogger_pkg::coord_t'(`FROG_SCREEN_SPAN);
	localparam frogger_pkg::coord_t ROW_TOP     = frogger_pkg::coord_t'(LANE_TOP);
	localparam frogger_pkg::coord_t ROW_END     = frogger_pkg::coord_t'(LANE_TOP + `FROG_LANE_H);

	logic       row_match;
	logic [3:0] slot_hit;

	assign row_match = (draw_y >= ROW_TOP) && (draw_y < ROW_END);  // top inclusive, end exclusive

	genvar k;
	generate
		for (k = 0; k < 4; k++)
		begin : g_slot
			localparam frogger_pkg::slot_count_t SLOT_IDX = frogger_pkg::slot_count_t'(k);

			frogger_pkg::coord_t span_end;
			logic                slot_live;

			assign span_end  = slot_x[k] + OBJ_SPAN;  // wraps modulo 2048
			assign slot_live = slot_count > SLOT_IDX;

			// a wrapped object re-enters from the left edge up to its end
			assign slot_hit[k] = slot_live &&
				((slot_x[k] < SCREEN_SPAN) ? ((draw_x >= slot_x[k]) && (draw_x <= span_end))
				                           : (draw_x <= span_end));
		end
	endgenerate

	assign lane_hit = row_match && (|slot_hit);

endmodule

// ==== logic/traffic_layer.sv ====
// traffic layer: car and lily pad lane hits, lane priority and object colour, registered
`timescale 1ns/1ns
`include "frogger_params.svh"

module traffic_layer
(
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                draw_valid,
	input  frogger_pkg::coord_t                 draw_x,
	input  frogger_pkg::coord_t                 draw_y,
	input  frogger_pkg::lane_slots_t [3:0]      car_x,
	input  frogger_pkg::slot_count_t [3:0]      car_count,
	input  frogger_pkg::lane_slots_t [3:0]      pad_x,
	input  frogger_pkg::slot_count_t [3:0]      pad_count,
	pixel_layer_if.object_src                   layer
);

	localparam frogger_pkg::rgb_t CAR_R_COLOR = `FROG_RGB_CAR_R;
	localparam frogger_pkg::rgb_t CAR_L_COLOR = `FROG_RGB_CAR_L;
	localparam frogger_pkg::rgb_t PAD_COLOR   = `FROG_RGB_PAD;

	logic [3:0]        road_hit;
	logic [3:0]        river_hit;
	logic              hit_next;
	frogger_pkg::rgb_t color_next;

	// ----------------------------------------
	// lane matchers
	// ----------------------------------------

	genvar i;
	generate
		for (i = 0; i < 4; i++)
		begin : g_lane
			lane_row_match
			#(
				.OBJ_WIDTH (`FROG_CAR_W),
				.LANE_TOP  (`FROG_ROAD_TOP + i * `FROG_LANE_H)
			)
			road_match_i
			(
				.draw_x     (draw_x),
				.draw_y     (draw_y),
				.slot_x     (car_x[i]),
				.slot_count (car_count[i]),
				.lane_hit   (road_hit[i])
			);

			lane_row_match
			#(
				.OBJ_WIDTH (`FROG_PAD_W),
				.LANE_TOP  (`FROG_RIVER_TOP + i * `FROG_LANE_H)
			)
			river_match_i
			(
				.draw_x     (draw_x),
				.draw_y     (draw_y),
				.slot_x     (pad_x[i]),
				.slot_count (pad_count[i]),
				.lane_hit   (river_hit[i])
			);
		end
	endgenerate

	// ----------------------------------------
	// priority and colour
	// ----------------------------------------

	always_comb
	begin
		hit_next   = |{road_hit, river_hit};
		color_next = PAD_COLOR;  // river lanes all share pad green
		// walk upward in priority so road lane 0 is applied last
		for (int n = 3; n >= 0; n--)
		begin
			if (road_hit[n])
				color_next = (n % 2 == 0) ? CAR_R_COLOR : CAR_L_COLOR;  // direction by lane
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			layer.valid     <= 1'b0;
			layer.obj_hit   <= 1'b0;
			layer.obj_color <= '0;
		end
		else
		begin
			layer.valid     <= draw_valid;
			layer.obj_hit   <= hit_next;
			layer.obj_color <= color_next;
		end
	end

endmodule

// ==== logic/scene_background.sv ====
// scene background: classifies the pixel into scenery bands, registered colour
`timescale 1ns/1ns
`include "frogger_params.svh"

module scene_background
(
	input  logic                clk,
	input  logic                reset,
	input  frogger_pkg::coord_t draw_x,
	input  frogger_pkg::coord_t draw_y,
	pixel_layer_if.scene_src    layer
);

	logic              water_band;
	logic              bay_row;
	logic              bay_cell;
	logic              gap_cell;
	logic              stripe_row;
	logic              stripe_dash;
	logic              grass_band;
	logic              road_band;
	frogger_pkg::rgb_t color_next;

	function automatic logic in_span(frogger_pkg::coord_t v, int lo, int hi);
		return (v >= frogger_pkg::coord_t'(lo)) && (v <= frogger_pkg::coord_t'(hi));
	endfunction

	// ----------------------------------------
	// band edges
	// ----------------------------------------

	assign water_band = in_span(draw_y, 80, 239);
	assign bay_row    = in_span(draw_y, 40, 79);   // goal row at the top

	assign bay_cell = in_span(draw_x, 0, 119) || in_span(draw_x, 160, 279) ||
	                  in_span(draw_x, 320, 479) || in_span(draw_x, 520, 679);
	assign gap_cell = in_span(draw_x, 120, 159) || in_span(draw_x, 280, 319) ||
	                  in_span(draw_x, 480, 519);  // grass between bays

	assign grass_band = in_span(draw_y, 240, 279) || (draw_y >= frogger_pkg::coord_t'(440)) ||
	                    (bay_row && gap_cell);

	// dashes straddle the boundaries between road lanes
	assign stripe_row  = in_span(draw_y, 318, 322) || in_span(draw_y, 358, 362) ||
	                     in_span(draw_y, 398, 402);
	assign stripe_dash = in_span(draw_x, 0, 100) || in_span(draw_x, 200, 300) ||
	                     in_span(draw_x, 400, 500) || (draw_x >= frogger_pkg::coord_t'(600));

	assign road_band = in_span(draw_y, 280, 439);

	always_comb
	begin
		if (water_band)
			color_next = `FROG_RGB_WATER;
		else if (bay_row && bay_cell)
			color_next = `FROG_RGB_BAY;
		else if (grass_band)
			color_next = `FROG_RGB_GRASS;
		else if (stripe_row && stripe_dash)
			color_next = `FROG_RGB_STRIPE;
		else if (road_band)
			color_next = `FROG_RGB_ROAD;  // pavement
		else
			color_next = `FROG_RGB_BLANK;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			layer.bg_color <= '0;
		else
			layer.bg_color <= color_next;  // same stage as the object layer
	end

endmodule

// ==== logic/pixel_compositor.sv ====
// pixel compositor: objects over scenery into the registered output pixel
`timescale 1ns/1ns

module pixel_compositor
(
	input  logic        clk,
	input  logic        reset,
	pixel_layer_if.sink layer,
	output logic        rgb_valid,
	output logic [7:0]  red,
	output logic [7:0]  green,
	output logic [7:0]  blue
);

	frogger_pkg::rgb_t pixel;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rgb_valid <= 1'b0;
			pixel     <= '0;
		end
		else
		begin
			rgb_valid <= layer.valid;  // single cycle per strobe
			if (layer.valid)
			begin
				// any object hides the scenery under it
				pixel <= layer.obj_hit ? layer.obj_color : layer.bg_color;
			end
		end
	end

	// held between results
	assign red   = pixel.red;
	assign green = pixel.green;
	assign blue  = pixel.blue;

endmodule

// ==== logic/frogger_pixel_top.sv ====
// frogger pixel top: two-stage colour pipeline from draw coordinate to 24-bit pixel
`timescale 1ns/1ns

module frogger_pixel_top
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           draw_valid,
	input  frogger_pkg::coord_t            draw_x,
	input  frogger_pkg::coord_t            draw_y,
	input  frogger_pkg::lane_slots_t [3:0] car_x,
	input  frogger_pkg::slot_count_t [3:0] car_count,
	input  frogger_pkg::lane_slots_t [3:0] pad_x,
	input  frogger_pkg::slot_count_t [3:0] pad_count,
	output logic                           rgb_valid,
	output logic [7:0]                     red,
	output logic [7:0]                     green,
	output logic [7:0]                     blue
);

	pixel_layer_if layer_bus ();

	// ----------------------------------------
	// stage one, both layers in parallel
	// ----------------------------------------

	traffic_layer traffic_layer_i
	(
		.clk        (clk),
		.reset      (reset),
		.draw_valid (draw_valid),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.car_x      (car_x),
		.car_count  (car_count),
		.pad_x      (pad_x),
		.pad_count  (pad_count),
		.layer      (layer_bus.object_src)
	);

	scene_background scene_background_i
	(
		.clk    (clk),
		.reset  (reset),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.layer  (layer_bus.scene_src)
	);

	// stage two
	pixel_compositor pixel_compositor_i
	(
		.clk       (clk),
		.reset     (reset),
		.layer     (layer_bus.sink),
		.rgb_valid (rgb_valid),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

// ==== tb/frogger_pixel_checker.sv ====
// pixel pipeline checker: strobe latency, reset and hold rules on the output
`timescale 1ns/1ns

module frogger_pixel_checker
(
	input logic       clk,
	input logic       reset,
	input logic       draw_valid,
	input logic       rgb_valid,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue
);

	int failure_count = 0;

	// result two edges behind its strobe once reset has left the pipe
	latency_a: assert property (@(posedge clk) disable iff (reset)
		(!$past(reset, 1) && !$past(reset, 2)) |-> (rgb_valid == $past(draw_valid, 2)))
		else
		begin
			failure_count++;
			$error("rgb_valid is not draw_valid delayed by two cycles");
		end

	reset_a: assert property (@(posedge clk) $fell(reset) |-> !rgb_valid)
		else
		begin
			failure_count++;
			$error("rgb_valid high in the cycle after reset");
		end

	// colour only moves together with a result
	hold_a: assert property (@(posedge clk) disable iff (reset)
		(!rgb_valid && !$past(reset)) |-> $stable({red, green, blue}))
		else
		begin
			failure_count++;
			$error("colour changed while rgb_valid was low");
		end

endmodule

bind frogger_pixel_top frogger_pixel_checker checker_i
(
	.clk        (clk),
	.reset      (reset),
	.draw_valid (draw_valid),
	.rgb_valid  (rgb_valid),
	.red        (red),
	.green      (green),
	.blue       (blue)
);

// ==== tb/frogger_pixel_tb.sv ====
// frogger pixel testbench: random lanes and pixels checked against a colour model
`timescale 1ns/1ns
`include "frogger_params.svh"

module frogger_pixel_tb;

	logic                           clk;
	logic                           reset;
	logic                           draw_valid;
	frogger_pkg::coord_t            draw_x;
	frogger_pkg::coord_t            draw_y;
	frogger_pkg::lane_slots_t [3:0] car_x;
	frogger_pkg::slot_count_t [3:0] car_count;
	frogger_pkg::lane_slots_t [3:0] pad_x;
	frogger_pkg::slot_count_t [3:0] pad_count;
	logic                           rgb_valid;
	logic [7:0]                     red;
	logic [7:0]                     green;
	logic [7:0]                     blue;

	integer      seed = 32'hae3755b0;
	int          cycle = 0;
	int          checks = 0;
	int          errors = 0;
	int          error_base = 0;
	logic [23:0] exp_rgb_q[$];   // model colours in strobe order
	int          exp_cycle_q[$]; // cycle each result is due

	frogger_pixel_top frogger_pixel_top_i
	(
		.clk        (clk),
		.reset      (reset),
		.draw_valid (draw_valid),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.car_x      (car_x),
		.car_count  (car_count),
		.pad_x      (pad_x),
		.pad_count  (pad_count),
		.rgb_valid  (rgb_valid),
		.red        (red),
		.green      (green),
		.blue       (blue)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	function automatic logic [23:0] scenery(int x, int y);
		bit bay_x;
		bit gap_x;
		bit dash_x;
		bay_x  = (x <= 119) || (x >= 160 && x <= 279) || (x >= 320 && x <= 479) ||
		         (x >= 520 && x <= 679);
		gap_x  = (x >= 120 && x <= 159) || (x >= 280 && x <= 319) || (x >= 480 && x <= 519);
		dash_x = (x <= 100) || (x >= 200 && x <= 300) || (x >= 400 && x <= 500) || (x >= 600);
		if (y >= 80 && y <= 239)
			return `FROG_RGB_WATER;
		if (y >= 40 && y <= 79 && bay_x)
			return `FROG_RGB_BAY;
		if ((y >= 240 && y <= 279) || y >= 440 || (y >= 40 && y <= 79 && gap_x))
			return `FROG_RGB_GRASS;
		if (((y >= 318 && y <= 322) || (y >= 358 && y <= 362) || (y >= 398 && y <= 402)) && dash_x)
			return `FROG_RGB_STRIPE;
		if (y >= 280 && y <= 439)
			return `FROG_RGB_ROAD;
		return `FROG_RGB_BLANK;
	endfunction

	function automatic bit covers(int sx, int width, int x);
		int span_end;
		span_end = (sx + width) % 2048;
		if (sx < `FROG_SCREEN_SPAN)
			return (x >= sx) && (x <= span_end);
		return x <= span_end;  // wrapped, enters from the left edge
	endfunction

	function automatic logic [23:0] expected_color(int x, int y);
		int top;
		for (int l = 0; l < 4; l++)
		begin
			top = `FROG_ROAD_TOP + l * `FROG_LANE_H;
			for (int k = 0; k < car_count[l]; k++)
			begin
				if (y >= top && y < top + `FROG_LANE_H && covers(car_x[l][k], `FROG_CAR_W, x))
					return (l % 2 == 0) ? `FROG_RGB_CAR_R : `FROG_RGB_CAR_L;
			end
		end
		for (int l = 0; l < 4; l++)
		begin
			top = `FROG_RIVER_TOP + l * `FROG_LANE_H;
			for (int k = 0; k < pad_count[l]; k++)
			begin
				if (y >= top && y < top + `FROG_LANE_H && covers(pad_x[l][k], `FROG_PAD_W, x))
					return `FROG_RGB_PAD;
			end
		end
		return scenery(x, y);
	endfunction

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic frogger_pkg::coord_t rand_slot_x(int width);
		if (rand_below(5) == 0)
			return frogger_pkg::coord_t'(2047 - rand_below(width + 40));  // past the right edge
		return frogger_pkg::coord_t'(rand_below(`FROG_SCREEN_SPAN));
	endfunction

	task automatic load_lanes(bit cars_on, bit pads_on, bit short_counts);
		for (int l = 0; l < 4; l++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				car_x[l][k] = rand_slot_x(`FROG_CAR_W);
				pad_x[l][k] = rand_slot_x(`FROG_PAD_W);
			end
			car_count[l] = !cars_on ? 3'd0 :
			               short_counts ? frogger_pkg::slot_count_t'(rand_below(4)) : 3'd4;
			pad_count[l] = !pads_on ? 3'd0 :
			               short_counts ? frogger_pkg::slot_count_t'(rand_below(4)) : 3'd4;
		end
	endtask

	// called 2 ns after a rising edge, returns 2 ns after the next one
	task automatic send_pixel(int x, int y);
		draw_valid = 1'b1;
		draw_x     = frogger_pkg::coord_t'(x);
		draw_y     = frogger_pkg::coord_t'(y);
		exp_rgb_q.push_back(expected_color(x, y));
		exp_cycle_q.push_back(cycle + 2);
		@(posedge clk);
		#2;
		draw_valid = 1'b0;
	endtask

	task automatic aim_pixel(bit river);
		int lane;
		int slot;
		int width;
		int sx;
		int top;
		lane  = rand_below(4);
		slot  = rand_below(4);
		width = river ? `FROG_PAD_W : `FROG_CAR_W;
		sx    = river ? pad_x[lane][slot] : car_x[lane][slot];
		top   = (river ? `FROG_RIVER_TOP : `FROG_ROAD_TOP) + lane * `FROG_LANE_H;
		// a few pixels past both ends of the span and the lane rows
		send_pixel((sx + width + 10 - rand_below(width + 20)) & 2047, top - 4 + rand_below(48));
	endtask

	task automatic idle(int n);
		draw_x = frogger_pkg::coord_t'(rand_below(800));  // coordinate moves without a strobe
		draw_y = frogger_pkg::coord_t'(rand_below(525));
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic drain_results();
		int t;
		t = 0;
		while (exp_rgb_q.size() > 0 && t < 20)
		begin
			@(posedge clk);
			t++;
		end
		if (exp_rgb_q.size() > 0)
		begin
			$display("timeout: %0d pixels never came back", exp_rgb_q.size());
			$display("TB FAILED");
			$finish;
		end
		#2;
	endtask

	task automatic end_test(int num, string name);
		drain_results();
		$display("test %0d %s: %0d errors", num, name, errors - error_base);
		error_base = errors;
	endtask

	// ----------------------------------------
	// output monitor
	// ----------------------------------------

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			$display("error t=%0t %s: got %h expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	always @(negedge clk)
	begin
		if (!reset && rgb_valid)
		begin
			if (exp_rgb_q.size() == 0)
			begin
				$display("rgb_valid high at %0t with no pixel outstanding", $time);
				errors++;
			end
			else
			begin
				check_value("rgb", {red, green, blue}, exp_rgb_q.pop_front());
				check_value("rgb_valid cycle", cycle, exp_cycle_q.pop_front());
			end
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial
	begin
		reset      = 1'b1;
		draw_valid = 1'b0;
		draw_x     = '0;
		draw_y     = '0;
		car_x      = '0;
		car_count  = '0;
		pad_x      = '0;
		pad_count  = '0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		load_lanes(1'b0, 1'b0, 1'b0);
		repeat (300) send_pixel(rand_below(800), rand_below(525));
		end_test(1, "scenery bands");

		for (int i = 0; i < 300; i++)
		begin
			if (i % 25 == 0)
				load_lanes(1'b1, 1'b0, 1'b0);
			aim_pixel(1'b0);
		end
		end_test(2, "car hits and wrap");

		for (int i = 0; i < 300; i++)
		begin
			if (i % 25 == 0)
				load_lanes(1'b0, 1'b1, 1'b0);
			aim_pixel(1'b1);
		end
		end_test(3, "pads over water");

		for (int i = 0; i < 300; i++)
		begin
			if (i % 20 == 0)
				load_lanes(1'b1, 1'b1, 1'b1);
			aim_pixel(rand_below(2));
		end
		end_test(4, "object counts");

		// mixed bursts and gaps, then a reset with pixels in flight
		load_lanes(1'b1, 1'b1, 1'b0);
		for (int i = 0; i < 200; i++)
		begin
			if (rand_below(3) == 0)
				idle(1 + rand_below(3));
			else
				aim_pixel(rand_below(2));
		end
		send_pixel(rand_below(800), rand_below(525));
		send_pixel(rand_below(800), rand_below(525));
		reset = 1'b1;
		@(posedge clk);
		#2;
		exp_rgb_q.delete();    // lost to the reset
		exp_cycle_q.delete();
		reset = 1'b0;
		idle(6);               // monitor flags any stray rgb_valid here
		repeat (20) aim_pixel(rand_below(2));
		end_test(5, "strobe timing and reset");

		errors = errors + frogger_pixel_top_i.checker_i.failure_count;
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
logic/frogger_pkg.sv
logic/pixel_layer_if.sv
logic/lane_row_match.sv
logic/traffic_layer.sv
logic/scene_background.sv
logic/pixel_compositor.sv
logic/frogger_pixel_top.sv
tb/frogger_pixel_checker.sv
tb/frogger_pixel_tb.sv

// ==== Bender.yml ====
package:
  name: frogger_pixel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/frogger_pkg.sv
      - logic/pixel_layer_if.sv
      - logic/lane_row_match.sv
      - logic/traffic_layer.sv
      - logic/scene_background.sv
      - logic/pixel_compositor.sv
      - logic/frogger_pixel_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/frogger_pixel_checker.sv
      - tb/frogger_pixel_tb.sv
